// ==== Makefile ====
SRCS := $(wildcard *.sv *.svh) flist.f

.PHONY: all run clean

all: obj_dir/Vtb_exec_cluster

obj_dir/Vtb_exec_cluster: $(SRCS)
	verilator --binary --timing -sv -f flist.f --top-module tb_exec_cluster \
		-o Vtb_exec_cluster

run: obj_dir/Vtb_exec_cluster
	./obj_dir/Vtb_exec_cluster > sim.log 2>&1; cat sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== alu_fu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_defs.svh"

module alu_fu import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  logic                  iss_valid,
    input  logic [`OPC_W-1:0]     iss_opcode,
    input  logic [`ALUOP_W-1:0]   iss_aluop,
    input  logic [`TAG_W-1:0]     iss_tag,
    input  logic [`DATA_W-1:0]    iss_val1,
    input  logic [`DATA_W-1:0]    iss_val2,
    input  logic [`DATA_W-1:0]    iss_imm,

    output logic [`TAG_W-1:0]     cdb1_tag,
    output logic [`DATA_W-1:0]    cdb1_value
);

    logic [`DATA_W-1:0] op2;
    logic [4:0]         shamt;
    logic [`DATA_W-1:0] result;

    // Register form reads operand 2, every other form the immediate
    assign op2   = (iss_opcode == opc_reg) ? iss_val2 : iss_imm;
    assign shamt = op2[4:0];

    always_comb begin
        if (iss_opcode == opc_lui) begin
            result = iss_imm;
        end else begin
            case (iss_aluop)
                aluop_add:  result = iss_val1 + op2;
                aluop_sub:  result = iss_val1 - op2;
                aluop_and:  result = iss_val1 & op2;
                aluop_or:   result = iss_val1 | op2;
                aluop_xor:  result = iss_val1 ^ op2;
                aluop_sll:  result = iss_val1 << shamt;
                aluop_srl:  result = iss_val1 >> shamt;
                aluop_sra:  result = $unsigned($signed(iss_val1) >>> shamt);
                aluop_slt: begin
                    result = {{(`DATA_W - 1){1'b0}}, $signed(iss_val1) < $signed(op2)};
                end
                aluop_sltu: begin
                    result = {{(`DATA_W - 1){1'b0}}, iss_val1 < op2};
                end
                default:    result = '0;
            endcase
        end
    end

    // A zero tag keeps CDB port 1 idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb1_tag <= '0;
        end else if (flush || !iss_valid) begin
            cdb1_tag <= '0;
        end else begin
            cdb1_tag <= iss_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            cdb1_value <= result;
        end
    end

endmodule

`default_nettype wire

// ==== exec_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_defs.svh"

module exec_cluster (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  logic                  disp_valid,
    input  logic [`OPC_W-1:0]     disp_opcode,
    input  logic [`ALUOP_W-1:0]   disp_aluop,
    input  logic [`TAG_W-1:0]     disp_tag,
    input  logic [`TAG_W-1:0]     disp_src1_tag,
    input  logic [`DATA_W-1:0]    disp_src1_value,
    input  logic [`TAG_W-1:0]     disp_src2_tag,
    input  logic [`DATA_W-1:0]    disp_src2_value,
    input  logic [`DATA_W-1:0]    disp_imm,

    // Outside unit results
    input  logic [`TAG_W-1:0]     cdb2_tag,
    input  logic [`DATA_W-1:0]    cdb2_value,

    output logic                  full,
    output logic [`TAG_W-1:0]     cdb1_tag,
    output logic [`DATA_W-1:0]    cdb1_value
);

    logic                 iss_valid;
    logic [`OPC_W-1:0]    iss_opcode;
    logic [`ALUOP_W-1:0]  iss_aluop;
    logic [`TAG_W-1:0]    iss_tag;
    logic [`DATA_W-1:0]   iss_val1;
    logic [`DATA_W-1:0]   iss_val2;
    logic [`DATA_W-1:0]   iss_imm;

    // CDB port 1 also feeds back for wakeup
    rs_station u_rs (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .disp_valid      (disp_valid),
        .disp_opcode     (disp_opcode),
        .disp_aluop      (disp_aluop),
        .disp_tag        (disp_tag),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_value (disp_src1_value),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_value (disp_src2_value),
        .disp_imm        (disp_imm),
        .cdb1_tag        (cdb1_tag),
        .cdb1_value      (cdb1_value),
        .cdb2_tag        (cdb2_tag),
        .cdb2_value      (cdb2_value),
        .full            (full),
        .iss_valid       (iss_valid),
        .iss_opcode      (iss_opcode),
        .iss_aluop       (iss_aluop),
        .iss_tag         (iss_tag),
        .iss_val1        (iss_val1),
        .iss_val2        (iss_val2),
        .iss_imm         (iss_imm)
    );

    alu_fu u_alu (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .iss_valid  (iss_valid),
        .iss_opcode (iss_opcode),
        .iss_aluop  (iss_aluop),
        .iss_tag    (iss_tag),
        .iss_val1   (iss_val1),
        .iss_val2   (iss_val2),
        .iss_imm    (iss_imm),
        .cdb1_tag   (cdb1_tag),
        .cdb1_value (cdb1_value)
    );

endmodule

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

`include "rs_defs.svh"

package exec_pkg;

    // Major opcodes, RISC-V style encodings
    localparam logic [`OPC_W-1:0] opc_reg = 7'h33;
    localparam logic [`OPC_W-1:0] opc_imm = 7'h13;
    localparam logic [`OPC_W-1:0] opc_lui = 7'h37;

    // ALU operations
    localparam logic [`ALUOP_W-1:0] aluop_add  = 4'd0;
    localparam logic [`ALUOP_W-1:0] aluop_sub  = 4'd1;
    localparam logic [`ALUOP_W-1:0] aluop_and  = 4'd2;
    localparam logic [`ALUOP_W-1:0] aluop_or   = 4'd3;
    localparam logic [`ALUOP_W-1:0] aluop_xor  = 4'd4;
    // Shifts take the low five bits of the second operand
    localparam logic [`ALUOP_W-1:0] aluop_sll  = 4'd5;
    localparam logic [`ALUOP_W-1:0] aluop_srl  = 4'd6;
    localparam logic [`ALUOP_W-1:0] aluop_sra  = 4'd7;
    // Set-less-than, signed and unsigned
    localparam logic [`ALUOP_W-1:0] aluop_slt  = 4'd8;
    localparam logic [`ALUOP_W-1:0] aluop_sltu = 4'd9;

endpackage

`default_nettype wire

// ==== flist.f ====
+incdir+.
exec_pkg.sv
rs_station.sv
alu_fu.sv
exec_cluster.sv
tb_checker.sv
tb_exec_cluster.sv

// ==== rs_defs.svh ====
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// Reservation station entries
`define RS_DEPTH 8

// ROB tag width, tag 0 is reserved for "no tag"
`define TAG_W 5

// Operand and result width
`define DATA_W 32

// Major opcode and ALU operation widths
`define OPC_W 7
`define ALUOP_W 4

`endif

// ==== rs_station.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_defs.svh"

module rs_station import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  logic                  disp_valid,
    input  logic [`OPC_W-1:0]     disp_opcode,
    input  logic [`ALUOP_W-1:0]   disp_aluop,
    input  logic [`TAG_W-1:0]     disp_tag,
    input  logic [`TAG_W-1:0]     disp_src1_tag,
    input  logic [`DATA_W-1:0]    disp_src1_value,
    input  logic [`TAG_W-1:0]     disp_src2_tag,
    input  logic [`DATA_W-1:0]    disp_src2_value,
    input  logic [`DATA_W-1:0]    disp_imm,

    input  logic [`TAG_W-1:0]     cdb1_tag,
    input  logic [`DATA_W-1:0]    cdb1_value,
    input  logic [`TAG_W-1:0]     cdb2_tag,
    input  logic [`DATA_W-1:0]    cdb2_value,

    output logic                  full,
    output logic                  iss_valid,
    output logic [`OPC_W-1:0]     iss_opcode,
    output logic [`ALUOP_W-1:0]   iss_aluop,
    output logic [`TAG_W-1:0]     iss_tag,
    output logic [`DATA_W-1:0]    iss_val1,
    output logic [`DATA_W-1:0]    iss_val2,
    output logic [`DATA_W-1:0]    iss_imm
);

    localparam int idx_w = $clog2(`RS_DEPTH);

    // Entry state
    logic [`RS_DEPTH-1:0] busy;
    logic [`OPC_W-1:0]    ent_opcode   [`RS_DEPTH];
    logic [`ALUOP_W-1:0]  ent_aluop    [`RS_DEPTH];
    logic [`TAG_W-1:0]    ent_dst_tag  [`RS_DEPTH];
    logic [`TAG_W-1:0]    ent_src1_tag [`RS_DEPTH];
    logic [`TAG_W-1:0]    ent_src2_tag [`RS_DEPTH];
    logic [`DATA_W-1:0]   ent_val1     [`RS_DEPTH];
    logic [`DATA_W-1:0]   ent_val2     [`RS_DEPTH];
    logic [`DATA_W-1:0]   ent_imm      [`RS_DEPTH];

    // Dispatch operands after the same-cycle CDB check
    logic [`TAG_W-1:0]    in_src1_tag;
    logic [`TAG_W-1:0]    in_src2_tag;
    logic [`DATA_W-1:0]   in_val1;
    logic [`DATA_W-1:0]   in_val2;

    logic [`RS_DEPTH-1:0] ready;
    logic [idx_w-1:0]     free_idx;
    logic                 free_found;
    logic [idx_w-1:0]     sel_idx;
    logic                 sel_found;

    // A waiting tag matches a live broadcast
    function automatic logic hit(input logic [`TAG_W-1:0] tag,
                                 input logic [`TAG_W-1:0] cdb);
        return (tag != '0) && (tag == cdb);
    endfunction

    assign full = &busy;

    always_comb begin
        in_src1_tag = disp_src1_tag;
        in_val1     = disp_src1_value;
        if (hit(disp_src1_tag, cdb1_tag)) begin
            in_src1_tag = '0;
            in_val1     = cdb1_value;
        end else if (hit(disp_src1_tag, cdb2_tag)) begin
            in_src1_tag = '0;
            in_val1     = cdb2_value;
        end

        in_src2_tag = disp_src2_tag;
        in_val2     = disp_src2_value;
        if (hit(disp_src2_tag, cdb1_tag)) begin
            in_src2_tag = '0;
            in_val2     = cdb1_value;
        end else if (hit(disp_src2_tag, cdb2_tag)) begin
            in_src2_tag = '0;
            in_val2     = cdb2_value;
        end

        // Operands the opcode never reads are ready at once
        if (disp_opcode != opc_reg) begin
            in_src2_tag = '0;
        end
        if (disp_opcode == opc_lui) begin
            in_src1_tag = '0;
        end
    end

    // Lowest free entry and lowest ready entry, scanned downward so index 0 wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        sel_found  = 1'b0;
        sel_idx    = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            ready[i] = busy[i] && (ent_src1_tag[i] == '0) && (ent_src2_tag[i] == '0);
            if (!busy[i]) begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
            if (ready[i]) begin
                sel_found = 1'b1;
                sel_idx   = idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= '0;
            iss_valid <= 1'b0;
        end else if (flush) begin
            busy      <= '0;
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= sel_found;
            if (sel_found) begin
                busy[sel_idx] <= 1'b0;
            end
            // The free entry is never the one issuing, both may update together
            if (disp_valid && free_found) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (disp_valid && free_found && free_idx == idx_w'(i)) begin
                ent_opcode[i]   <= disp_opcode;
                ent_aluop[i]    <= disp_aluop;
                ent_dst_tag[i]  <= disp_tag;
                ent_src1_tag[i] <= in_src1_tag;
                ent_src2_tag[i] <= in_src2_tag;
                ent_val1[i]     <= in_val1;
                ent_val2[i]     <= in_val2;
                ent_imm[i]      <= disp_imm;
            end else if (busy[i]) begin
                // Wakeup, port 1 first
                if (hit(ent_src1_tag[i], cdb1_tag)) begin
                    ent_src1_tag[i] <= '0;
                    ent_val1[i]     <= cdb1_value;
                end else if (hit(ent_src1_tag[i], cdb2_tag)) begin
                    ent_src1_tag[i] <= '0;
                    ent_val1[i]     <= cdb2_value;
                end
                if (hit(ent_src2_tag[i], cdb1_tag)) begin
                    ent_src2_tag[i] <= '0;
                    ent_val2[i]     <= cdb1_value;
                end else if (hit(ent_src2_tag[i], cdb2_tag)) begin
                    ent_src2_tag[i] <= '0;
                    ent_val2[i]     <= cdb2_value;
                end
            end
        end

        if (sel_found) begin
            iss_opcode <= ent_opcode[sel_idx];
            iss_aluop  <= ent_aluop[sel_idx];
            iss_tag    <= ent_dst_tag[sel_idx];
            iss_val1   <= ent_val1[sel_idx];
            iss_val2   <= ent_val2[sel_idx];
            iss_imm    <= ent_imm[sel_idx];
        end
    end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_defs.svh"

module tb_checker import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  logic [`OPC_W-1:0]     disp_opcode,
    input  logic [`ALUOP_W-1:0]   disp_aluop,
    input  logic [`TAG_W-1:0]     disp_tag,
    input  logic [`TAG_W-1:0]     disp_src1_tag,
    input  logic [`DATA_W-1:0]    disp_src1_value,
    input  logic [`TAG_W-1:0]     disp_src2_tag,
    input  logic [`DATA_W-1:0]    disp_src2_value,
    input  logic [`DATA_W-1:0]    disp_imm,
    input  logic [`TAG_W-1:0]     cdb1_tag,
    input  logic [`DATA_W-1:0]    cdb1_value,
    input  logic [`TAG_W-1:0]     cdb2_tag,
    input  logic [`DATA_W-1:0]    cdb2_value,
    input  logic                  full,
    input  logic [7:0]            phase,
    output int                    errors,
    output int                    pending
);

    // Dispatched instructions not yet broadcast
    // Indexed by destination tag
    logic                 pend  [32];
    logic [`OPC_W-1:0]    p_opc [32];
    logic [`ALUOP_W-1:0]  p_op  [32];
    logic [`TAG_W-1:0]    p_t1  [32];
    logic [`TAG_W-1:0]    p_t2  [32];
    logic [`DATA_W-1:0]   p_v1  [32];
    logic [`DATA_W-1:0]   p_v2  [32];
    logic [`DATA_W-1:0]   p_imm [32];

    function automatic string phase_name(input logic [7:0] p);
        case (p)
            8'd1:    return "reset_latency";
            8'd2:    return "independent";
            8'd3:    return "alu_chains";
            8'd4:    return "port2_wakeup";
            8'd5:    return "station_full";
            8'd6:    return "flush";
            default: return "idle";
        endcase
    endfunction

    // Second operand picked by the opcode form
    function automatic logic [`DATA_W-1:0] model_result(input logic [`OPC_W-1:0] opc,
            input logic [`ALUOP_W-1:0] op, input logic [`DATA_W-1:0] a,
            input logic [`DATA_W-1:0] rb, input logic [`DATA_W-1:0] imm);
        logic [`DATA_W-1:0] b;
        b = (opc == opc_reg) ? rb : imm;
        if (opc == opc_lui)
            return imm;
        case (op)
            aluop_add:  return a + b;
            aluop_sub:  return a - b;
            aluop_and:  return a & b;
            aluop_or:   return a | b;
            aluop_xor:  return a ^ b;
            aluop_sll:  return a << b[4:0];
            aluop_srl:  return a >> b[4:0];
            aluop_sra:  return $unsigned($signed(a) >>> b[4:0]);
            aluop_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluop_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:    return '0;
        endcase
    endfunction

    // Port 1 wins when both ports carry the waited tag
    task automatic resolve(inout logic [`TAG_W-1:0] t, inout logic [`DATA_W-1:0] v);
        if (t != 0 && t == cdb1_tag) begin
            t = 0;
            v = cdb1_value;
        end else if (t != 0 && t == cdb2_tag) begin
            t = 0;
            v = cdb2_value;
        end
    endtask

    always @(posedge clk) begin
        logic [`TAG_W-1:0]  t;
        logic [`DATA_W-1:0] exp;
        if (rst) begin
            for (int i = 0; i < 32; i++)
                pend[i] = 1'b0;
            errors  = 0;
            pending = 0;
        end else begin
            // Every busy entry is still pending in the model
            if (full && pending < `RS_DEPTH) begin
                errors++;
                $display("Station reported full with only %0d instructions in flight",
                         pending);
            end
            if (cdb1_tag != 0) begin
                t = cdb1_tag;
                if (!pend[t]) begin
                    errors++;
                    $display("Tag %0d was broadcast on CDB port 1 with nothing pending", t);
                end else if ((p_opc[t] != opc_lui && p_t1[t] != 0) ||
                             (p_opc[t] == opc_reg && p_t2[t] != 0)) begin
                    errors++;
                    $display("Tag %0d was broadcast before its operands were available", t);
                    pend[t] = 1'b0;
                end else begin
                    exp = model_result(p_opc[t], p_op[t], p_v1[t], p_v2[t], p_imm[t]);
                    if (exp !== cdb1_value) begin
                        errors++;
                        $display("ERR %s: tag %0d expected %h actual %h",
                                 phase_name(phase), t, exp, cdb1_value);
                    end
                    pend[t] = 1'b0;
                end
            end
            for (int i = 1; i < 32; i++) begin
                if (pend[i]) begin
                    resolve(p_t1[i], p_v1[i]);
                    resolve(p_t2[i], p_v2[i]);
                end
            end
            if (disp_valid && !flush) begin
                t = disp_tag;
                if (pend[t]) begin
                    errors++;
                    $display("Tag %0d was dispatched again while still pending", t);
                end
                pend[t]  = 1'b1;
                p_opc[t] = disp_opcode;
                p_op[t]  = disp_aluop;
                p_t1[t]  = disp_src1_tag;
                p_v1[t]  = disp_src1_value;
                p_t2[t]  = disp_src2_tag;
                p_v2[t]  = disp_src2_value;
                p_imm[t] = disp_imm;
                resolve(p_t1[t], p_v1[t]);
                resolve(p_t2[t], p_v2[t]);
            end
            // Flush cancels everything still in the station or the ALU
            if (flush) begin
                for (int i = 0; i < 32; i++)
                    pend[i] = 1'b0;
            end
            pending = 0;
            for (int i = 0; i < 32; i++)
                if (pend[i])
                    pending++;
        end
    end

endmodule

`default_nettype wire

// ==== tb_exec_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_defs.svh"

module tb_exec_cluster import exec_pkg::*; ();

    localparam int n_disp = 121;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 disp_valid;
    logic [`OPC_W-1:0]    disp_opcode;
    logic [`ALUOP_W-1:0]  disp_aluop;
    logic [`TAG_W-1:0]    disp_tag;
    logic [`TAG_W-1:0]    disp_src1_tag;
    logic [`DATA_W-1:0]   disp_src1_value;
    logic [`TAG_W-1:0]    disp_src2_tag;
    logic [`DATA_W-1:0]   disp_src2_value;
    logic [`DATA_W-1:0]   disp_imm;
    logic [`TAG_W-1:0]    cdb2_tag;
    logic [`DATA_W-1:0]   cdb2_value;
    logic                 full;
    logic [`TAG_W-1:0]    cdb1_tag;
    logic [`DATA_W-1:0]   cdb1_value;
    logic [7:0]           phase;
    int                   chk_errors;
    int                   chk_pending;
    int                   tb_errors;

    // Tag bookkeeping for ALU results and outside-unit results
    logic [31:0]          lcg;
    logic                 alu_busy [32];
    logic                 p2_busy  [32];
    logic [`TAG_W-1:0]    p2_q[$];
    logic                 p2_auto;

    exec_cluster dut (
        .clk(clk), .rst(rst), .flush(flush),
        .disp_valid(disp_valid), .disp_opcode(disp_opcode), .disp_aluop(disp_aluop),
        .disp_tag(disp_tag), .disp_src1_tag(disp_src1_tag),
        .disp_src1_value(disp_src1_value), .disp_src2_tag(disp_src2_tag),
        .disp_src2_value(disp_src2_value), .disp_imm(disp_imm),
        .cdb2_tag(cdb2_tag), .cdb2_value(cdb2_value),
        .full(full), .cdb1_tag(cdb1_tag), .cdb1_value(cdb1_value)
    );

    tb_checker chk (
        .clk(clk), .rst(rst), .flush(flush),
        .disp_valid(disp_valid), .disp_opcode(disp_opcode), .disp_aluop(disp_aluop),
        .disp_tag(disp_tag), .disp_src1_tag(disp_src1_tag),
        .disp_src1_value(disp_src1_value), .disp_src2_tag(disp_src2_tag),
        .disp_src2_value(disp_src2_value), .disp_imm(disp_imm),
        .cdb1_tag(cdb1_tag), .cdb1_value(cdb1_value),
        .cdb2_tag(cdb2_tag), .cdb2_value(cdb2_value),
        .full(full), .phase(phase), .errors(chk_errors), .pending(chk_pending)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (cdb1_tag != 0)
            alu_busy[cdb1_tag] = 1'b0;
    end

    function automatic logic [31:0] rnd();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg;
    endfunction

    function automatic int pick(input int n);
        return int'((rnd() >> 16) % 32'(n));
    endfunction

    function automatic logic [`TAG_W-1:0] alloc_tag();
        int s;
        s = pick(31);
        for (int i = 0; i < 31; i++) begin
            if (!alu_busy[(s + i) % 31 + 1] && !p2_busy[(s + i) % 31 + 1])
                return 5'((s + i) % 31 + 1);
        end
        return '0;
    endfunction

    function automatic logic any_alu_busy();
        for (int i = 1; i < 32; i++)
            if (alu_busy[i])
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        cdb2_tag   = '0;
    endtask

    task automatic release_tag(input int i);
        cdb2_tag   = p2_q[i];
        cdb2_value = rnd();
        p2_busy[p2_q[i]] = 1'b0;
        p2_q.delete(i);
    endtask

    task automatic release_maybe();
        if (p2_auto && p2_q.size() > 0 && pick(3) == 0)
            release_tag(pick(p2_q.size()));
    endtask

    // Mode 0 ready only, 1 adds ALU dependences, 2 adds outside-unit tags
    task automatic pick_src(input int mode, output logic [4:0] t, output logic [31:0] v);
        int s;
        int r;
        t = '0;
        v = rnd();
        r = pick(4);
        if (mode >= 1 && r == 2) begin
            s = pick(31);
            for (int i = 0; i < 31; i++)
                if (t == 0 && alu_busy[(s + i) % 31 + 1])
                    t = 5'((s + i) % 31 + 1);
        end else if (mode == 2 && r == 3 && p2_q.size() < 6) begin
            t = alloc_tag();
            if (t != 0) begin
                p2_busy[t] = 1'b1;
                p2_q.push_back(t);
            end
        end
    endtask

    task automatic send(input logic [6:0] opc, input logic [3:0] op,
                        input logic [4:0] t1, input logic [31:0] v1,
                        input logic [4:0] t2, input logic [31:0] v2,
                        input logic [31:0] imm, output logic [4:0] tag);
        tag = alloc_tag();
        while (full || tag == 0) begin
            release_maybe();
            step();
            tag = alloc_tag();
        end
        alu_busy[tag]   = 1'b1;
        disp_valid      = 1'b1;
        disp_opcode     = opc;
        disp_aluop      = op;
        disp_tag        = tag;
        disp_src1_tag   = t1;
        disp_src1_value = v1;
        disp_src2_tag   = t2;
        disp_src2_value = v2;
        disp_imm        = imm;
        release_maybe();
        step();
    endtask

    task automatic random_instr(input int mode);
        logic [6:0]  opc;
        logic [4:0]  t1;
        logic [4:0]  t2;
        logic [4:0]  tag;
        logic [31:0] v1;
        logic [31:0] v2;
        int          r;
        // Source tags are named only in the cycle that dispatches them
        while (full) begin
            release_maybe();
            step();
        end
        r   = pick(3);
        opc = (r == 0) ? opc_reg : (r == 1) ? opc_imm : opc_lui;
        pick_src(mode, t1, v1);
        pick_src(mode, t2, v2);
        send(opc, 4'(pick(10)), t1, v1, t2, v2, rnd(), tag);
        repeat (pick(3)) begin
            release_maybe();
            step();
        end
    endtask

    task automatic drain();
        p2_auto = 1'b1;
        while (any_alu_busy() || p2_q.size() > 0) begin
            release_maybe();
            step();
        end
        repeat (3) step();
    endtask

    task automatic expect_bit(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            tb_errors++;
            $display("ERR %s: %s expected %0b actual %0b", what, "level", exp, act);
        end
    endtask

    initial begin
        #(n_disp * 40 * 8);
        $display("Timeout: the run did not finish within the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [4:0] tag;
        logic [4:0] t;
        lcg             = 32'he17557f6;
        clk             = 0;
        rst             = 1;
        flush           = 0;
        disp_valid      = 0;
        phase           = 0;
        tb_errors       = 0;
        disp_opcode     = '0;
        disp_aluop      = '0;
        disp_tag        = '0;
        disp_imm        = '0;
        disp_src1_tag   = '0;
        disp_src1_value = '0;
        disp_src2_tag   = '0;
        disp_src2_value = '0;
        cdb2_tag        = '0;
        cdb2_value      = '0;
        p2_auto         = 1'b1;
        for (int i = 0; i < 32; i++) begin
            alu_busy[i] = 1'b0;
            p2_busy[i]  = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1 rst = 0;

        // Idle after reset, then one ready instruction into an empty station
        phase = 1;
        repeat (3) begin
            step();
            expect_bit(full, 1'b0, "reset_full");
            if (cdb1_tag != 0) begin
                tb_errors++;
                $display("CDB port 1 was active before any dispatch");
            end
        end
        send(opc_reg, aluop_add, 0, 32'h1234, 0, 32'h0f0f, 0, tag);
        step();
        step();
        if (cdb1_tag !== tag) begin
            tb_errors++;
            $display("ERR reset_latency: tag expected %0d actual %0d", tag, cdb1_tag);
        end

        phase = 2;
        repeat (40) random_instr(0);
        drain();
        phase = 3;
        repeat (30) random_instr(1);
        drain();
        phase = 4;
        repeat (30) random_instr(2);
        drain();

        // Fill all entries with instructions waiting on the outside unit
        phase   = 5;
        p2_auto = 1'b0;
        repeat (8) begin
            t = alloc_tag();
            p2_busy[t] = 1'b1;
            p2_q.push_back(t);
            send(opc_imm, aluop_xor, t, 0, 0, 0, rnd(), tag);
        end
        expect_bit(full, 1'b1, "station_full");
        repeat (6) begin
            step();
            if (cdb1_tag != 0) begin
                tb_errors++;
                $display("CDB port 1 broadcast while every entry was waiting");
            end
        end
        release_tag(0);
        step();
        for (int i = 0; i < 4 && full; i++)
            step();
        expect_bit(full, 1'b0, "full_release");
        drain();

        // Flush with pending work, then normal traffic again
        phase   = 6;
        p2_auto = 1'b0;
        repeat (6) random_instr(2);
        flush = 1'b1;
        step();
        flush = 1'b0;
        for (int i = 0; i < 32; i++) begin
            alu_busy[i] = 1'b0;
            p2_busy[i]  = 1'b0;
        end
        p2_q.delete();
        expect_bit(full, 1'b0, "flush_full");
        repeat (5) step();
        repeat (6) random_instr(0);
        drain();

        if (chk_pending != 0) begin
            tb_errors++;
            $display("%0d dispatched instructions were never broadcast", chk_pending);
        end
        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
